// ==== include/readout_defines.svh ====
`ifndef READOUT_DEFINES_SVH
`define READOUT_DEFINES_SVH

//////////////////////////////////////////////////
// Readout word and synchroniser sizing
//////////////////////////////////////////////////

// Bits per ASIC RAM word
`define WORD_WIDTH 16

// Falling-edge resync depth
// for serial data and TransmitOn
`define SYNC_STAGES 3

`endif

// ==== hw/ReadoutPkg.sv ====
`include "readout_defines.svh"

package ReadoutPkg;

	// Per-chain readout FSM
	typedef enum logic [1:0] {
		Idle = 2'b00,
		Read = 2'b01,
		Done = 2'b10
	} ReadoutState;

	// One word from the ASIC RAM
	typedef logic [`WORD_WIDTH-1:0] AsicWord;

	// Source chain tag, 0 or 1
	typedef logic ChainId;

endpackage

// ==== hw/AsicRamReadout.sv ====
`timescale 1ns/100ps
`include "readout_defines.svh"

module AsicRamReadout import ReadoutPkg::*; #(
	parameter int SyncStages = `SYNC_STAGES
) (
	input  logic    ReadClk,
	input  logic    reset_n,
	input  logic    AsicDin,
	input  logic    TransmitOn,
	output AsicWord Word,
	output logic    WordValid,
	output logic    ChainDone
);

	// Bit counter sizing
	localparam int CountWidth = $clog2(`WORD_WIDTH);
	localparam logic [CountWidth-1:0] LastBit = CountWidth'(`WORD_WIDTH - 1);

	// Resync chains, oldest sample in the MSB
	logic [SyncStages-1:0] dinSync;
	logic [SyncStages-1:0] txSync;

	// Views of the resynced inputs
	logic dinBit;
	logic txEarly;
	logic txLate;

	// FSM and packer
	ReadoutState state;
	ReadoutState nextState;
	logic [CountWidth-1:0] bitCount;
	AsicWord shiftReg;
	AsicWord nextWord;
	logic shiftEn;
	logic wordEnd;

	//////////////////////////////////////////////////
	// Falling-edge resync
	//////////////////////////////////////////////////

	// Serial data
	always_ff @(negedge ReadClk) begin
		dinSync <= {dinSync[SyncStages-2:0], AsicDin};
	end

	// TransmitOn idles high
	always_ff @(negedge ReadClk or negedge reset_n) begin
		if (!reset_n)
			txSync <= '1;
		else
			txSync <= {txSync[SyncStages-2:0], TransmitOn};
	end

	// ASIC sends its bits inverted
	assign dinBit  = ~dinSync[SyncStages-1];
	// One stage early, so the first bit lands in the first Read cycle
	assign txEarly = txSync[SyncStages-2];
	// Aligned with dinBit
	assign txLate  = txSync[SyncStages-1];

	//////////////////////////////////////////////////
	// Readout FSM
	//////////////////////////////////////////////////

	always_ff @(posedge ReadClk or negedge reset_n) begin
		if (!reset_n)
			state <= Idle;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = state;
		case (state)
			Idle: if (!txEarly) nextState = Read;
			Read: if (txLate) nextState = Done;
			Done: nextState = Idle;
			default: nextState = Idle;
		endcase
	end

	// Done lasts exactly one cycle
	assign ChainDone = (state == Done);

	//////////////////////////////////////////////////
	// Serial to word packer, MSB first
	//////////////////////////////////////////////////

	// Valid bit only while TransmitOn still low
	assign shiftEn  = (state == Read) && !txLate;
	assign nextWord = {shiftReg[`WORD_WIDTH-2:0], dinBit};
	assign wordEnd  = shiftEn && (bitCount == LastBit);

	// Idle clear drops any partial word
	always_ff @(posedge ReadClk or negedge reset_n) begin
		if (!reset_n)
			bitCount <= '0;
		else if (state == Idle)
			bitCount <= '0;
		else if (wordEnd)
			bitCount <= '0;
		else if (shiftEn)
			bitCount <= bitCount + 1'b1;
	end

	// Word held steady under its strobe
	always_ff @(posedge ReadClk) begin
		if (shiftEn)
			shiftReg <= nextWord;
		if (wordEnd)
			Word <= nextWord;
	end

	// Strobe with the sixteenth bit
	always_ff @(posedge ReadClk or negedge reset_n) begin
		if (!reset_n)
			WordValid <= 1'b0;
		else
			WordValid <= wordEnd;
	end

endmodule

// ==== hw/ReadoutMerger.sv ====
`timescale 1ns/100ps

module ReadoutMerger import ReadoutPkg::*; (
	input  logic    ReadClk,
	input  logic    reset_n,
	input  AsicWord Word0,
	input  logic    WordValid0,
	input  logic    ChainDone0,
	input  AsicWord Word1,
	input  logic    WordValid1,
	input  logic    ChainDone1,
	input  logic    FifoFull,
	output AsicWord FifoData,
	output ChainId  FifoChain,
	output logic    FifoWriteEn,
	output logic    Overrun,
	output logic    ReadDone
);

	// Per-chain views of the inputs
	AsicWord wordIn [2];
	logic [1:0] validIn;
	logic [1:0] doneIn;

	// One hold slot per chain
	AsicWord slotWord [2];
	logic [1:0] slotFull;

	// Drain choice for this cycle
	logic [1:0] drain;
	logic drainAny;
	ChainId drainSel;

	// End of readout
	logic [1:0] doneLatch;
	logic allDone;

	assign wordIn[0]  = Word0;
	assign wordIn[1]  = Word1;
	assign validIn    = {WordValid1, WordValid0};
	assign doneIn     = {ChainDone1, ChainDone0};

	//////////////////////////////////////////////////
	// Slot arbitration
	//////////////////////////////////////////////////

	// Nothing drains while full, chain 0 first
	always_comb begin
		drain = 2'b00;
		if (!FifoFull) begin
			if (slotFull[0])
				drain[0] = 1'b1;
			else if (slotFull[1])
				drain[1] = 1'b1;
		end
	end

	assign drainAny = |drain;
	// Slot 1 picked only when slot 0 is not
	assign drainSel = drain[1];

	//////////////////////////////////////////////////
	// Hold slots and overrun
	//////////////////////////////////////////////////

	// Slot draining this edge may take a new word
	always_ff @(posedge ReadClk) begin
		for (int i = 0; i < 2; i++) begin
			if (validIn[i] && (!slotFull[i] || drain[i]))
				slotWord[i] <= wordIn[i];
		end
	end

	always_ff @(posedge ReadClk or negedge reset_n) begin
		if (!reset_n) begin
			slotFull <= 2'b00;
			Overrun  <= 1'b0;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (validIn[i]) begin
					// Occupied and stuck, new word lost
					if (slotFull[i] && !drain[i])
						Overrun <= 1'b1;
					else
						slotFull[i] <= 1'b1;
				end else if (drain[i]) begin
					slotFull[i] <= 1'b0;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// FIFO write port, one cycle after the choice
	//////////////////////////////////////////////////

	always_ff @(posedge ReadClk) begin
		if (drainAny) begin
			FifoData  <= slotWord[drainSel];
			FifoChain <= drainSel;
		end
	end

	always_ff @(posedge ReadClk or negedge reset_n) begin
		if (!reset_n)
			FifoWriteEn <= 1'b0;
		else
			FifoWriteEn <= drainAny;
	end

	//////////////////////////////////////////////////
	// Combined done
	//////////////////////////////////////////////////

	// Both chains finished and nothing left to write
	assign allDone = (&doneLatch) && !(|slotFull) && !(|validIn);

	always_ff @(posedge ReadClk or negedge reset_n) begin
		if (!reset_n) begin
			doneLatch <= 2'b00;
			ReadDone  <= 1'b0;
		end else begin
			ReadDone <= allDone;
			if (allDone)
				doneLatch <= 2'b00;
			else
				doneLatch <= doneLatch | doneIn;
		end
	end

endmodule

// ==== hw/DifReadoutTop.sv ====
`timescale 1ns/100ps

module DifReadoutTop import ReadoutPkg::*; (
	input  logic    ReadClk,
	input  logic    reset_n,
	input  logic    AsicDin0,
	input  logic    TransmitOn0,
	input  logic    AsicDin1,
	input  logic    TransmitOn1,
	input  logic    FifoFull,
	output AsicWord FifoData,
	output ChainId  FifoChain,
	output logic    FifoWriteEn,
	output logic    Overrun,
	output logic    ReadDone
);

	// Chain 0 word stream
	AsicWord word0;
	logic wordValid0;
	logic chainDone0;

	// Chain 1 word stream
	AsicWord word1;
	logic wordValid1;
	logic chainDone1;

	//////////////////////////////////////////////////
	// One readout block per daisy chain
	//////////////////////////////////////////////////

	AsicRamReadout chain0_i (
		.ReadClk    (ReadClk),
		.reset_n    (reset_n),
		.AsicDin    (AsicDin0),
		.TransmitOn (TransmitOn0),
		.Word       (word0),
		.WordValid  (wordValid0),
		.ChainDone  (chainDone0)
	);

	AsicRamReadout chain1_i (
		.ReadClk    (ReadClk),
		.reset_n    (reset_n),
		.AsicDin    (AsicDin1),
		.TransmitOn (TransmitOn1),
		.Word       (word1),
		.WordValid  (wordValid1),
		.ChainDone  (chainDone1)
	);

	// Shared FIFO write port
	ReadoutMerger merger_i (
		.ReadClk     (ReadClk),
		.reset_n     (reset_n),
		.Word0       (word0),
		.WordValid0  (wordValid0),
		.ChainDone0  (chainDone0),
		.Word1       (word1),
		.WordValid1  (wordValid1),
		.ChainDone1  (chainDone1),
		.FifoFull    (FifoFull),
		.FifoData    (FifoData),
		.FifoChain   (FifoChain),
		.FifoWriteEn (FifoWriteEn),
		.Overrun     (Overrun),
		.ReadDone    (ReadDone)
	);

endmodule

// ==== testbench/DifReadout_asserts.sv ====
`timescale 1ns/100ps

module DifReadout_asserts import ReadoutPkg::*; (
	input logic ReadClk,
	input logic reset_n,
	input logic FifoFull,
	input logic FifoWriteEn,
	input logic ReadDone,
	input logic Overrun
);

	// Tally of failed properties, summed into the testbench result
	int failCount = 0;

	//////////////////////////////////////////////////
	// Write port rules
	//////////////////////////////////////////////////

	// Full seen at an edge blocks the next write
	fullBlocksWrite: assert property (@(posedge ReadClk) disable iff (!reset_n)
		FifoFull |=> !FifoWriteEn)
	else begin
		failCount++;
		$error("FifoWriteEn high in the cycle after FifoFull");
	end

	// Single-cycle done pulse
	readDonePulse: assert property (@(posedge ReadClk) disable iff (!reset_n)
		ReadDone |=> !ReadDone)
	else begin
		failCount++;
		$error("ReadDone held for more than one cycle");
	end

	// Sticky until reset
	overrunSticky: assert property (@(posedge ReadClk) disable iff (!reset_n)
		Overrun |=> Overrun)
	else begin
		failCount++;
		$error("Overrun fell without a reset");
	end

	// Quiet outputs right after reset release
	quietAfterReset: assert property (@(posedge ReadClk)
		$rose(reset_n) |-> !FifoWriteEn && !ReadDone && !Overrun)
	else begin
		failCount++;
		$error("Outputs not low in the cycle after reset release");
	end

endmodule

bind DifReadoutTop DifReadout_asserts asserts_i (
	.ReadClk     (ReadClk),
	.reset_n     (reset_n),
	.FifoFull    (FifoFull),
	.FifoWriteEn (FifoWriteEn),
	.ReadDone    (ReadDone),
	.Overrun     (Overrun)
);

// ==== testbench/DifReadoutTb.sv ====
`timescale 1ns/100ps

module DifReadoutTb import ReadoutPkg::*; ();

	localparam int WordBits   = $bits(AsicWord);
	// All five tests take under a thousand cycles
	localparam int CycleLimit = 20000;
	// FifoFull window of test 5, counted from the first driven bit
	localparam int FullStart  = 47;
	localparam int FullCycles = 40;

	// DUT ports
	logic ReadClk;
	logic reset_n;
	logic AsicDin0;
	logic TransmitOn0;
	logic AsicDin1;
	logic TransmitOn1;
	logic FifoFull;
	AsicWord FifoData;
	ChainId FifoChain;
	logic FifoWriteEn;
	logic Overrun;
	logic ReadDone;

	// Scoreboard
	logic [31:0] lfsr;
	AsicWord expWords0 [$];
	AsicWord expWords1 [$];
	int writeCount [2];
	int readDoneCount = 0;
	int errorCount = 0;
	int testsFailed = 0;
	int timeoutCycles;

	// Marks taken at the start of each test
	int errMark;
	int doneMark;
	int writeMark0;
	int writeMark1;

	DifReadoutTop dut_i (
		.ReadClk     (ReadClk),
		.reset_n     (reset_n),
		.AsicDin0    (AsicDin0),
		.TransmitOn0 (TransmitOn0),
		.AsicDin1    (AsicDin1),
		.TransmitOn1 (TransmitOn1),
		.FifoFull    (FifoFull),
		.FifoData    (FifoData),
		.FifoChain   (FifoChain),
		.FifoWriteEn (FifoWriteEn),
		.Overrun     (Overrun),
		.ReadDone    (ReadDone)
	);

	initial begin
		ReadClk = 1'b0;
		forever #4 ReadClk = ~ReadClk;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] stepLfsr(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic takeBit();
		lfsr = stepLfsr(lfsr);
		return lfsr[0];
	endfunction

	function automatic int totalErrors();
		return errorCount + dut_i.asserts_i.failCount;
	endfunction

	task automatic expectValue(input string name, input int got, input int want);
		if (got != want) begin
			errorCount++;
			$display("** Error: %s = %h, expected %h", name, got, want);
		end
	endtask

	task automatic driveChain(input int chain, input logic din, input logic txOn);
		if (chain == 0) begin
			AsicDin0    <= din;
			TransmitOn0 <= txOn;
		end else begin
			AsicDin1    <= din;
			TransmitOn1 <= txOn;
		end
	endtask

	task automatic pushExpected(input int chain, input AsicWord word);
		if (chain == 0)
			expWords0.push_back(word);
		else
			expWords1.push_back(word);
	endtask

	// One transmission, line carries each bit inverted, MSB first
	task automatic sendChain(input int chain, input int startDelay, input int numWords,
			input int extraBits, input bit modelFull);
		AsicWord word;
		logic bitVal;
		logic inWindow;
		int relCycle;
		int held;
		word = '0;
		held = 0;
		relCycle = startDelay - 1;
		repeat (startDelay) @(posedge ReadClk);
		for (int w = 0; w < numWords; w++) begin
			for (int b = 0; b < WordBits; b++) begin
				bitVal = takeBit();
				word = {word[WordBits-2:0], bitVal};
				@(posedge ReadClk);
				relCycle++;
				driveChain(chain, ~bitVal, 1'b0);
			end
			// Slot keeps the first word finished under FifoFull, later ones are lost
			inWindow = modelFull && relCycle >= FullStart
				&& relCycle < FullStart + FullCycles;
			if (inWindow)
				held++;
			if (!inWindow || held == 1)
				pushExpected(chain, word);
		end
		// Trailing partial word
		for (int b = 0; b < extraBits; b++) begin
			bitVal = takeBit();
			@(posedge ReadClk);
			driveChain(chain, ~bitVal, 1'b0);
		end
		@(posedge ReadClk);
		driveChain(chain, 1'b0, 1'b1);
	endtask

	task automatic holdFifoFull();
		repeat (FullStart + 1) @(posedge ReadClk);
		FifoFull <= 1'b1;
		repeat (FullCycles) @(posedge ReadClk);
		FifoFull <= 1'b0;
	endtask

	task automatic checkFifoWrite();
		AsicWord want;
		int pending;
		if (FifoChain == 1'b0)
			pending = expWords0.size();
		else
			pending = expWords1.size();
		if (pending == 0) begin
			errorCount++;
			$display("Write tagged chain %0d arrived with no word outstanding", FifoChain);
		end else begin
			if (FifoChain == 1'b0)
				want = expWords0.pop_front();
			else
				want = expWords1.pop_front();
			writeCount[FifoChain]++;
			if (FifoData !== want) begin
				errorCount++;
				$display("** Error: FifoData = %h, expected %h (chain %0d)",
					FifoData, want, FifoChain);
			end
		end
	endtask

	task automatic waitForDrain();
		while (expWords0.size() != 0 || expWords1.size() != 0)
			@(posedge ReadClk);
	endtask

	task automatic waitForReadDone();
		while (readDoneCount == doneMark)
			@(posedge ReadClk);
	endtask

	task automatic startTest();
		errMark    = totalErrors();
		doneMark   = readDoneCount;
		writeMark0 = writeCount[0];
		writeMark1 = writeCount[1];
	endtask

	task automatic endTest(input int num, input string name);
		if (totalErrors() > errMark) begin
			testsFailed++;
			$display("Test %0d, %s: failed", num, name);
		end else begin
			$display("Test %0d, %s: passed", num, name);
		end
	endtask

	task automatic expectCounts(input int writes0, input int writes1, input int dones);
		expectValue("chain 0 writes", writeCount[0] - writeMark0, writes0);
		expectValue("chain 1 writes", writeCount[1] - writeMark1, writes1);
		expectValue("ReadDone pulses", readDoneCount - doneMark, dones);
	endtask

	//////////////////////////////////////////////////
	// Output monitor, sampled mid-cycle
	//////////////////////////////////////////////////

	// A write in the same cycle as ReadDone still counts as outstanding
	always @(negedge ReadClk) begin
		if (reset_n === 1'b1) begin
			if (ReadDone) begin
				readDoneCount++;
				if (expWords0.size() != 0 || expWords1.size() != 0) begin
					errorCount++;
					$display("ReadDone pulsed while words were still outstanding");
				end
			end
			if (FifoWriteEn)
				checkFifoWrite();
		end
	end

	initial begin : watchdog
		for (timeoutCycles = 0; timeoutCycles < CycleLimit; timeoutCycles++)
			@(posedge ReadClk);
		$display("Run stopped after %0d cycles without finishing the tests", CycleLimit);
		$display("TEST FAILED");
		$finish;
	end

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin : stimulus
		lfsr = 32'hb586;
		writeCount[0] = 0;
		writeCount[1] = 0;
		reset_n     <= 1'b0;
		AsicDin0    <= 1'b0;
		TransmitOn0 <= 1'b1;
		AsicDin1    <= 1'b0;
		TransmitOn1 <= 1'b1;
		FifoFull    <= 1'b0;
		repeat (3) @(posedge ReadClk);
		reset_n <= 1'b1;

		// Lines idle, nothing may come out
		startTest();
		repeat (20) @(posedge ReadClk);
		expectCounts(0, 0, 0);
		expectValue("Overrun", int'(Overrun), 0);
		endTest(1, "idle after reset");

		// Chain 1 never finishes, so no ReadDone
		startTest();
		sendChain(0, 0, 8, 0, 1'b0);
		waitForDrain();
		repeat (40) @(posedge ReadClk);
		expectCounts(8, 0, 0);
		endTest(2, "chain 0 alone");

		// Chain 1 ends last
		startTest();
		fork
			sendChain(0, 0, 8, 0, 1'b0);
			sendChain(1, 24, 8, 0, 1'b0);
		join
		waitForReadDone();
		repeat (20) @(posedge ReadClk);
		expectCounts(8, 8, 1);
		endTest(3, "both chains staggered");

		// Five trailing bits on each chain
		startTest();
		fork
			sendChain(0, 0, 3, 5, 1'b0);
			sendChain(1, 7, 2, 5, 1'b0);
		join
		waitForReadDone();
		repeat (20) @(posedge ReadClk);
		expectCounts(3, 2, 1);
		endTest(4, "partial word dropped");

		// Three words per chain finish under FifoFull, two of them lost
		startTest();
		fork
			sendChain(0, 0, 8, 0, 1'b1);
			sendChain(1, 2, 8, 0, 1'b1);
			holdFifoFull();
		join
		waitForReadDone();
		repeat (20) @(posedge ReadClk);
		expectCounts(6, 6, 1);
		expectValue("Overrun", int'(Overrun), 1);
		endTest(5, "FIFO full overrun");

		$display("5 tests run, %0d failed, %0d errors", testsFailed, totalErrors());
		if (testsFailed == 0 && totalErrors() == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+include
hw/ReadoutPkg.sv
hw/AsicRamReadout.sv
hw/ReadoutMerger.sv
hw/DifReadoutTop.sv
testbench/DifReadout_asserts.sv
testbench/DifReadoutTb.sv

// ==== Makefile ====
# Verilator run of the DIF readout testbench

SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := DifReadoutTb
FILELIST := all.f
OBJDIR   := obj_dir
RUNFLAGS := +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run $(TOP), fail unless the pass message is printed"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP) $(RUNFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJDIR)
